// File: fetchPkg.sv
`default_nettype none

package fetchPkg;

   // byte address, one instruction word per two bytes
   typedef logic [15:0] addr_t;

   // opcode [15:11], first source [10:8], second source [7:5]
   typedef logic [15:0] instr_t;

   typedef logic [2:0] regIdx_t;

   // write-back source of the instruction in decode
   typedef enum logic [1:0] {
      wbAlu,
      wbMem,
      wbPc,
      wbImm
   } wbSel_t;

   // one-hot operand source, fwdRf is the register file written this cycle
   typedef enum logic [4:0] {
      fwdNone = 5'b00001,
      fwdX    = 5'b00010,
      fwdM    = 5'b00100,
      fwdW    = 5'b01000,
      fwdRf   = 5'b10000
   } fwdSel_t;

   // pending register write in one later stage
   typedef struct packed {
      logic    regWrt;
      regIdx_t wrtReg;
   } stageWr_t;

   typedef struct packed {
      fwdSel_t fwdA;
      fwdSel_t fwdB;
   } fwdCtrl_t;

   localparam instr_t InstrNop  = 16'h0800;
   localparam instr_t InstrHalt = 16'h0000;

   function automatic regIdx_t getSrcA(instr_t word);
      return word[10:8];
   endfunction

   function automatic regIdx_t getSrcB(instr_t word);
      return word[7:5];
   endfunction

endpackage

`default_nettype wire

// File: pcUnit.sv
`default_nettype none

module pcUnit (
   input  wire                      clk,
   input  wire                      rstN,
   input  wire fetchPkg::addr_t     newPC,
   input  wire                      redirect,
   input  wire                      advance,
   output fetchPkg::addr_t          pc,
   output fetchPkg::addr_t          pcPlus2,
   output logic                     incOverflow
);
   import fetchPkg::*;

   localparam addr_t PcStep = 16'd2;

   logic [16:0] incSum;

   // carry out of bit 15 means the next fetch would wrap past 16'hFFFE
   assign incSum      = {1'b0, pc} + {1'b0, PcStep};
   assign pcPlus2     = incSum[15:0];
   assign incOverflow = incSum[16];

   // redirect wins over sequential advance
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (redirect) begin
         pc <= newPC;
      end else if (advance) begin
         pc <= pcPlus2;
      end
   end

   // the top level only advances from an aligned PC
   aAlignedAdvance: assert property (
      @(posedge clk) disable iff (!rstN)
      (advance && !redirect) |=> !pc[0]
   );

endmodule

`default_nettype wire

// File: instrMem.sv
`default_nettype none

module instrMem #(
   parameter int WordsPerLine = 4,
   parameter int MemLatency   = 4
) (
   input  wire                                     clk,
   input  wire                                     rstN,
   input  wire                                     rdStrobe,
   input  wire fetchPkg::addr_t                    lineAddr,
   output fetchPkg::instr_t [WordsPerLine-1:0]     line,
   output logic                                    done
);
   import fetchPkg::*;

   localparam int MemWords = 32;
   localparam int MemAw    = $clog2(MemWords);
   localparam int CntW     = $clog2(MemLatency);

   // done is registered, so the countdown starts two short of the latency
   if (MemLatency < 2) begin : gLatencyCheck
      $error("instrMem needs MemLatency of at least 2");
   end

   instr_t mem [MemWords];

   logic            busy;
   logic [CntW-1:0] count;
   addr_t           pendAddr;
   logic [MemAw-1:0] baseWord;

   initial begin
      $readmemh("program.hex", mem);
   end

   // upper address bits wrap around the small image
   assign baseWord = pendAddr[MemAw:1];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         busy  <= 1'b0;
         count <= '0;
         done  <= 1'b0;
      end else begin
         done <= 1'b0;
         if (rdStrobe) begin
            busy  <= 1'b1;
            count <= CntW'(MemLatency - 2);
         end else if (busy) begin
            if (count == '0) begin
               busy <= 1'b0;
               done <= 1'b1;
            end else begin
               count <= count - 1'b1;
            end
         end
      end
   end

   // block read as the countdown expires
   always_ff @(posedge clk) begin
      if (rdStrobe) begin
         pendAddr <= lineAddr;
      end
      if (busy && count == '0) begin
         for (int w = 0; w < WordsPerLine; w++) begin
            line[w] <= mem[baseWord + MemAw'(w)];
         end
      end
   end

   aNoStrobeWhileBusy: assert property (
      @(posedge clk) disable iff (!rstN)
      rdStrobe |-> !busy
   );

endmodule

`default_nettype wire

// File: instrCache.sv
`default_nettype none

module instrCache #(
   parameter int CacheLines   = 16,
   parameter int WordsPerLine = 4
) (
   input  wire                                        clk,
   input  wire                                        rstN,
   input  wire fetchPkg::addr_t                       pc,
   input  wire fetchPkg::instr_t [WordsPerLine-1:0]   line,
   input  wire                                        done,
   output fetchPkg::instr_t                           fetchWord,
   output logic                                       hit,
   output logic                                       stall,
   output logic                                       rdStrobe,
   output fetchPkg::addr_t                            lineAddr
);
   import fetchPkg::*;

   // address split into tag, index, word offset and byte bit
   localparam int OffW   = $clog2(WordsPerLine);
   localparam int IdxW   = $clog2(CacheLines);
   localparam int TagLsb = 1 + OffW + IdxW;
   localparam int TagW   = 16 - TagLsb;

   typedef enum logic [1:0] {
      stIdle,
      stRequest,
      stWait
   } cacheState_t;

   cacheState_t state;
   cacheState_t stateNext;

   logic [CacheLines-1:0]     valid;
   logic [TagW-1:0]           tags [CacheLines];
   instr_t [WordsPerLine-1:0] data [CacheLines];

   logic [OffW-1:0] wordSel;
   logic [IdxW-1:0] idx;
   logic [IdxW-1:0] fillIdx;
   logic [TagW-1:0] pcTag;
   addr_t           fillAddr;
   logic            lookupHit;

   assign wordSel = pc[OffW:1];
   assign idx     = pc[TagLsb-1 -: IdxW];
   assign pcTag   = pc[15:TagLsb];
   assign fillIdx = fillAddr[TagLsb-1 -: IdxW];

   // lookup is purely combinational in the cycle the PC is presented
   assign lookupHit = valid[idx] && (tags[idx] == pcTag);
   assign fetchWord = data[idx][wordSel];

   // no hits are reported while a fill is in flight, even after a redirect
   assign hit   = (state == stIdle) && lookupHit;
   assign stall = (state != stIdle) || !lookupHit;

   assign rdStrobe = (state == stRequest);
   assign lineAddr = {fillAddr[15:OffW+1], {(OffW+1){1'b0}}};

   always_comb begin
      stateNext = state;
      case (state)
         stIdle: begin
            if (!lookupHit) begin
               stateNext = stRequest;
            end
         end
         stRequest: begin
            stateNext = stWait;
         end
         stWait: begin
            if (done) begin
               stateNext = stIdle;
            end
         end
         default: begin
            stateNext = stIdle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
      end else begin
         state <= stateNext;
      end
   end

   // miss address is captured once since the PC may move during the fill
   always_ff @(posedge clk) begin
      if (state == stIdle && !lookupHit) begin
         fillAddr <= pc;
      end
   end

   // line fill on done
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         valid <= '0;
         for (int i = 0; i < CacheLines; i++) begin
            tags[i] <= '0;
            data[i] <= '0;
         end
      end else if (state == stWait && done) begin
         valid[fillIdx] <= 1'b1;
         tags[fillIdx]  <= fillAddr[15:TagLsb];
         data[fillIdx]  <= line;
      end
   end

   // memory answers only while a fill is waiting
   aDoneInWait: assert property (
      @(posedge clk) disable iff (!rstN)
      done |-> (state == stWait)
   );

endmodule

`default_nettype wire

// File: hazardDetect.sv
`default_nettype none

module hazardDetect (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire fetchPkg::instr_t     fetchWord,
   input  wire                       hit,
   input  wire fetchPkg::addr_t      pcPlus2,
   input  wire                       misalign,
   input  wire                       jumpInstD,
   input  wire                       jumpInstX,
   input  wire                       branchMispredict,
   input  wire fetchPkg::stageWr_t   wrD,
   input  wire fetchPkg::stageWr_t   wrX,
   input  wire fetchPkg::stageWr_t   wrM,
   input  wire fetchPkg::stageWr_t   wrW,
   input  wire fetchPkg::wbSel_t     wbSelD,
   output fetchPkg::instr_t          instruction,
   output fetchPkg::addr_t           incPC,
   output fetchPkg::fwdCtrl_t        fwd,
   output logic                      pcHold
);
   import fetchPkg::*;

   // newest writer first; decode's writer will sit in X next cycle
   function automatic fwdSel_t pickSrc(regIdx_t src, stageWr_t d, stageWr_t x,
                                       stageWr_t m, stageWr_t w);
      if (d.regWrt && d.wrtReg == src) begin
         return fwdX;
      end
      if (x.regWrt && x.wrtReg == src) begin
         return fwdM;
      end
      if (m.regWrt && m.wrtReg == src) begin
         return fwdW;
      end
      if (w.regWrt && w.wrtReg == src) begin
         return fwdRf;
      end
      return fwdNone;
   endfunction

   regIdx_t  srcA;
   regIdx_t  srcB;
   logic     loadHazard;
   logic     loadUse;
   logic     bubbled;
   logic     flush;
   logic     insertNop;
   instr_t   nextInstr;
   fwdCtrl_t nextFwd;

   assign srcA = getSrcA(fetchWord);
   assign srcB = getSrcB(fetchWord);

   // load in decode feeding the word being fetched
   assign loadHazard = hit && !misalign && (wbSelD == wbMem) && wrD.regWrt &&
                       (wrD.wrtReg == srcA || wrD.wrtReg == srcB);

   // one bubble is enough, the word passes on the following cycle
   assign loadUse = loadHazard && !bubbled;
   assign pcHold  = loadUse;

   assign flush     = jumpInstD || jumpInstX || branchMispredict;
   assign insertNop = !hit || flush || loadUse;

   always_comb begin
      nextInstr    = fetchWord;
      nextFwd.fwdA = pickSrc(srcA, wrD, wrX, wrM, wrW);
      nextFwd.fwdB = pickSrc(srcB, wrD, wrX, wrM, wrW);
      // misaligned fetch outranks every bubble
      if (misalign) begin
         nextInstr    = InstrHalt;
         nextFwd.fwdA = fwdNone;
         nextFwd.fwdB = fwdNone;
      end else if (insertNop) begin
         nextInstr    = InstrNop;
         nextFwd.fwdA = fwdNone;
         nextFwd.fwdB = fwdNone;
      end
   end

   // fetch-to-decode register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         instruction <= InstrNop;
         incPC       <= '0;
         fwd         <= '{fwdA: fwdNone, fwdB: fwdNone};
         bubbled     <= 1'b0;
      end else begin
         instruction <= nextInstr;
         incPC       <= pcPlus2;
         fwd         <= nextFwd;
         bubbled     <= loadUse && !flush;
      end
   end

endmodule

`default_nettype wire

// File: fetchStage.sv
`default_nettype none

module fetchStage #(
   parameter int CacheLines   = 16,
   parameter int WordsPerLine = 4,
   parameter int MemLatency   = 4
) (
   input  wire                       clk,
   input  wire                       rstN,
   input  wire fetchPkg::addr_t      newPC,
   input  wire                       jumpInstD,
   input  wire                       jumpInstX,
   input  wire                       branchMispredict,
   input  wire fetchPkg::stageWr_t   wrD,
   input  wire fetchPkg::stageWr_t   wrX,
   input  wire fetchPkg::stageWr_t   wrM,
   input  wire fetchPkg::stageWr_t   wrW,
   input  wire fetchPkg::wbSel_t     wbSelD,
   output fetchPkg::instr_t          instruction,
   output fetchPkg::addr_t           incPC,
   output fetchPkg::fwdCtrl_t        fwd,
   output logic                      err
);
   import fetchPkg::*;

   addr_t                     pc;
   addr_t                     pcPlus2;
   addr_t                     memLineAddr;
   instr_t                    fetchWord;
   instr_t [WordsPerLine-1:0] memLine;
   logic                      hit;
   logic                      stall;
   logic                      memRdStrobe;
   logic                      memDone;
   logic                      pcHold;
   logic                      misalign;
   logic                      redirect;
   logic                      advance;
   logic                      incOverflow;

   assign misalign = pc[0];
   assign redirect = jumpInstX || branchMispredict;

   // an odd PC stays put until the next redirect
   assign advance = !stall && !pcHold && !jumpInstD && !misalign;

   pcUnit i_pcUnit (
      .clk         (clk),
      .rstN        (rstN),
      .newPC       (newPC),
      .redirect    (redirect),
      .advance     (advance),
      .pc          (pc),
      .pcPlus2     (pcPlus2),
      .incOverflow (incOverflow)
   );

   instrCache #(
      .CacheLines   (CacheLines),
      .WordsPerLine (WordsPerLine)
   ) i_instrCache (
      .clk       (clk),
      .rstN      (rstN),
      .pc        (pc),
      .line      (memLine),
      .done      (memDone),
      .fetchWord (fetchWord),
      .hit       (hit),
      .stall     (stall),
      .rdStrobe  (memRdStrobe),
      .lineAddr  (memLineAddr)
   );

   instrMem #(
      .WordsPerLine (WordsPerLine),
      .MemLatency   (MemLatency)
   ) i_instrMem (
      .clk      (clk),
      .rstN     (rstN),
      .rdStrobe (memRdStrobe),
      .lineAddr (memLineAddr),
      .line     (memLine),
      .done     (memDone)
   );

   hazardDetect i_hazardDetect (
      .clk              (clk),
      .rstN             (rstN),
      .fetchWord        (fetchWord),
      .hit              (hit),
      .pcPlus2          (pcPlus2),
      .misalign         (misalign),
      .jumpInstD        (jumpInstD),
      .jumpInstX        (jumpInstX),
      .branchMispredict (branchMispredict),
      .wrD              (wrD),
      .wrX              (wrX),
      .wrM              (wrM),
      .wrW              (wrW),
      .wbSelD           (wbSelD),
      .instruction      (instruction),
      .incPC            (incPC),
      .fwd              (fwd),
      .pcHold           (pcHold)
   );

   // lines up with the instruction register
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         err <= 1'b0;
      end else begin
         err <= misalign || incOverflow;
      end
   end

endmodule

`default_nettype wire

// File: fetchTb.sv
`default_nettype none

module fetchTb;
   timeunit 1ns;
   timeprecision 100ps;

   import fetchPkg::*;

   localparam int CacheLines   = 16;
   localparam int WordsPerLine = 4;
   localparam int MemLatency   = 4;
   localparam int ImageWords   = 32;
   localparam int MissCost     = MemLatency + 2;
   localparam int WaitLimit    = 40;
   localparam int NumRows      = 24;

   localparam stageWr_t NoWr    = '0;
   localparam fwdCtrl_t FwdIdle = '{fwdA: fwdNone, fwdB: fwdNone};

   typedef enum logic [2:0] {
      kindSeq, kindRedirect, kindReuse, kindLoadUse, kindFwd, kindHalt
   } rowKind_t;

   typedef struct packed {
      addr_t    target;
      logic     jumpX;
      logic     mispredict;
      stageWr_t wrD;
      stageWr_t wrX;
      stageWr_t wrM;
      stageWr_t wrW;
      wbSel_t   wbSelD;
      rowKind_t kind;
   } row_t;

   logic     clk;
   logic     rstN;
   addr_t    newPC;
   logic     jumpInstD;
   logic     jumpInstX;
   logic     branchMispredict;
   stageWr_t wrD;
   stageWr_t wrX;
   stageWr_t wrM;
   stageWr_t wrW;
   wbSel_t   wbSelD;
   instr_t   instruction;
   addr_t    incPC;
   fwdCtrl_t fwd;
   logic     err;

   row_t   rows [NumRows];
   instr_t image [ImageWords];
   logic   mValid [CacheLines];
   int     mTag [CacheLines];
   int     checks;
   int     errors;

   fetchStage #(
      .CacheLines   (CacheLines),
      .WordsPerLine (WordsPerLine),
      .MemLatency   (MemLatency)
   ) i_fetchStage (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // wr fields of fwd and load-use rows are filled in at run time
   task automatic fillTable();
      rows[0]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[1]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[2]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[3]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[4]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[5]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[6]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[7]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbMem, kindLoadUse};
      rows[8]  = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[9]  = '{16'h0030, 1'b1, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindRedirect};
      rows[10] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[11] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbMem, kindLoadUse};
      rows[12] = '{16'h0004, 1'b0, 1'b1, NoWr, NoWr, NoWr, NoWr, wbAlu, kindReuse};
      rows[13] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[14] = '{16'h000b, 1'b1, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindHalt};
      rows[15] = '{16'h0014, 1'b0, 1'b1, NoWr, NoWr, NoWr, NoWr, wbAlu, kindRedirect};
      rows[16] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[17] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
      rows[18] = '{16'h0020, 1'b1, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindRedirect};
      rows[19] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbMem, kindLoadUse};
      rows[20] = '{16'h0010, 1'b1, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindReuse};
      rows[21] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[22] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindFwd};
      rows[23] = '{16'h0000, 1'b0, 1'b0, NoWr, NoWr, NoWr, NoWr, wbAlu, kindSeq};
   endtask

   function automatic instr_t imageWord(addr_t a);
      return image[(int'(a) / 2) % ImageWords];
   endfunction

   // line number of a byte address
   function automatic int lineOf(addr_t a);
      return int'(a) / (2 * WordsPerLine);
   endfunction

   // cache index and tag follow from the line number
   function automatic logic isCached(addr_t a);
      int idx;
      idx = lineOf(a) % CacheLines;
      return mValid[idx] && (mTag[idx] == lineOf(a) / CacheLines);
   endfunction

   task automatic markCached(addr_t a);
      mValid[lineOf(a) % CacheLines] = 1'b1;
      mTag[lineOf(a) % CacheLines]   = lineOf(a) / CacheLines;
   endtask

   // wr[3] is decode and wr[0] is writeback so newer matches overwrite older ones
   function automatic fwdSel_t expectSel(regIdx_t src, stageWr_t [3:0] wr);
      fwdSel_t pick;
      pick = fwdNone;
      if (wr[0].regWrt && wr[0].wrtReg == src) pick = fwdRf;
      if (wr[1].regWrt && wr[1].wrtReg == src) pick = fwdW;
      if (wr[2].regWrt && wr[2].wrtReg == src) pick = fwdM;
      if (wr[3].regWrt && wr[3].wrtReg == src) pick = fwdX;
      return pick;
   endfunction

   function automatic fwdCtrl_t expectFwd(instr_t word, stageWr_t [3:0] wr);
      fwdCtrl_t f;
      f.fwdA = expectSel(word[10:8], wr);
      f.fwdB = expectSel(word[7:5], wr);
      return f;
   endfunction

   task automatic checkInstr(input instr_t got, input instr_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkAddr(input addr_t got, input addr_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkFwd(input fwdCtrl_t got, input fwdCtrl_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   task automatic checkErr(input logic got, input logic exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
      end
   endtask

   // bubbles are NOP or HALT outputs seen before the awaited one
   task automatic waitOutput(input logic wantHalt, output int bubbles, output logic timedOut);
      int   cycles;
      logic found;
      bubbles  = 0;
      cycles   = 0;
      found    = 1'b0;
      timedOut = 1'b0;
      while (!found && !timedOut) begin
         @(negedge clk);
         cycles++;
         if (wantHalt ? (instruction == InstrHalt) :
             (instruction != InstrNop && instruction != InstrHalt)) begin
            found = 1'b1;
         end else if (cycles >= WaitLimit) begin
            timedOut = 1'b1;
         end else begin
            bubbles++;
         end
      end
   endtask

   initial begin
      row_t        cur;
      rowKind_t    kind;
      instr_t      word;
      addr_t       pcCur;
      addr_t       wordAddr;
      logic        inErr;
      logic        redirecting;
      logic        loadUse;
      logic        timedOut;
      logic [31:0] rnd;
      int          bubbles;
      int          waited;
      int          expBubbles;
      int          errBefore;
      int          rowsDone;

      void'($urandom(32'h6f61_84d6));
      $readmemh("program.hex", image);
      fillTable();
      for (int i = 0; i < CacheLines; i++) begin
         mValid[i] = 1'b0;
         mTag[i]   = 0;
      end
      checks           = 0;
      errors           = 0;
      rowsDone         = 0;
      rstN             = 1'b0;
      newPC            = '0;
      jumpInstD        = 1'b0;
      jumpInstX        = 1'b0;
      branchMispredict = 1'b0;
      wrD              = NoWr;
      wrX              = NoWr;
      wrM              = NoWr;
      wrW              = NoWr;
      wbSelD           = wbAlu;

      repeat (16) @(negedge clk);
      rstN = 1'b1;
      checkInstr(instruction, InstrNop, "instruction after reset");
      checkFwd(fwd, FwdIdle, "fwd after reset");
      checkErr(err, 1'b0, "err after reset");
      $display("reset values: %s", errors == 0 ? "ok" : "mismatch");

      pcCur    = '0;
      inErr    = 1'b0;
      timedOut = 1'b0;
      for (int r = 0; r < NumRows && !timedOut; r++) begin
         cur         = rows[r];
         kind        = cur.kind;
         errBefore   = errors;
         redirecting = cur.jumpX || cur.mispredict;
         wordAddr    = redirecting ? cur.target : pcCur;
         word        = imageWord(wordAddr);
         rnd         = $urandom;
         if (kind == kindFwd) begin
            cur.wrD = rnd[3:0];
            cur.wrX = rnd[7:4];
            cur.wrM = rnd[11:8];
            cur.wrW = rnd[15:12];
         end
         // decode holds a load into the first source of the next word
         if (kind == kindLoadUse) begin
            cur.wrD = '{regWrt: 1'b1, wrtReg: word[10:8]};
         end

         newPC            = cur.target;
         jumpInstX        = cur.jumpX;
         branchMispredict = cur.mispredict;
         wrD              = cur.wrD;
         wrX              = cur.wrX;
         wrM              = cur.wrM;
         wrW              = cur.wrW;
         wbSelD           = cur.wbSelD;

         expBubbles = 0;
         bubbles    = 0;
         if (redirecting) begin
            // the PC skipped by the redirect may still start a fill
            if (!isCached(pcCur) && kind != kindHalt) begin
               expBubbles = MissCost - 1;
            end
            markCached(pcCur);
            @(negedge clk);
            jumpInstX        = 1'b0;
            branchMispredict = 1'b0;
            checkInstr(instruction, inErr ? InstrHalt : InstrNop, "bubble after redirect");
            expBubbles = expBubbles + 1;
            bubbles    = 1;
         end
         if (kind == kindReuse && !isCached(wordAddr)) begin
            errors++;
            $display("row %0d redirects to a line that was never fetched", r);
         end
         if (kind != kindHalt && !isCached(wordAddr)) begin
            expBubbles = expBubbles + MissCost;
         end
         markCached(wordAddr);
         loadUse = (cur.wbSelD == wbMem) && cur.wrD.regWrt &&
                   (cur.wrD.wrtReg == word[10:8] || cur.wrD.wrtReg == word[7:5]);
         if (loadUse) begin
            expBubbles = expBubbles + 1;
         end

         waitOutput(kind == kindHalt, waited, timedOut);
         bubbles = bubbles + waited;
         if (timedOut) begin
            $display("timeout: no instruction came out of the fetch stage in row %0d", r);
         end else if (kind == kindHalt) begin
            checkErr(err, 1'b1, "err on odd PC");
            checkAddr(incPC, wordAddr + 16'd2, "incPC on odd PC");
            checkFwd(fwd, FwdIdle, "fwd on odd PC");
            // frozen PC keeps HALT and incPC steady
            repeat (3) begin
               @(negedge clk);
               checkInstr(instruction, InstrHalt, "instruction while frozen");
               checkAddr(incPC, wordAddr + 16'd2, "incPC while frozen");
               checkErr(err, 1'b1, "err while frozen");
            end
            inErr = 1'b1;
            pcCur = wordAddr;
         end else begin
            checkInstr(instruction, word, "instruction");
            checkAddr(incPC, wordAddr + 16'd2, "incPC");
            checkFwd(fwd, expectFwd(word, {cur.wrD, cur.wrX, cur.wrM, cur.wrW}), "fwd");
            checkErr(err, 1'b0, "err");
            inErr = 1'b0;
            pcCur = wordAddr + 16'd2;
         end
         if (!timedOut) begin
            checks++;
            if (bubbles != expBubbles) begin
               errors++;
               $display("FAIL %0t: row %0d gave %0d bubbles, expected %0d",
                        $time, r, bubbles, expBubbles);
            end
         end
         $display("row %0d %s: %s", r, kind.name(), errors == errBefore ? "ok" : "mismatch");
         rowsDone++;
      end

      $display("rows %0d of %0d, checks %0d, errors %0d", rowsDone, NumRows, checks, errors);
      if (errors == 0 && !timedOut) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: program.hex
// one 16-bit instruction word per line, word address 0 first
// opcode [15:11], first source [10:8], second source [7:5]
2109
3a4c
4b21
5c63
1d85
6ea7
7fc9
80eb
910d
a22f
b351
c473
d595
e6b7
f7d9
08fb
191d
2a3f
3b41
4c62
5d84
6ea6
7fc8
80ea
910c
a22e
b350
c472
d594
e6b6
f7d8
1234

// File: tb.f
fetchPkg.sv
pcUnit.sv
instrMem.sv
instrCache.sv
hazardDetect.sv
fetchStage.sv
fetchTb.sv

// File: run.sh
#!/bin/sh
# build the fetch stage testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module fetchTb -o fetchSim || exit 1
./obj_dir/fetchSim | tee /dev/stderr | grep -qx "Verification passed" && exit 0 || exit 1
